/* Makefile */
TOP = door_lock_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f door_lock_top.f -o $(TOP) --Mdir obj_dir
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then exit 1; fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* door_lock_top.f */
hw/lock_pkg.sv
hw/display_pkg.sv
hw/pin_if.sv
hw/keypad_scanner.sv
hw/pin_entry.sv
hw/pin_checker.sv
hw/lock_controller.sv
hw/seg_display.sv
hw/door_lock_top.sv
test/door_lock_tb.sv

/* hw/display_pkg.sv */
// Glyph codes and active-low segment words for the six-digit display.
// seg_encode turns one glyph into its segment pattern.
`default_nettype none

package display_pkg;

  typedef enum logic [3:0] {
    GLYPH_0     = 4'd0,
    GLYPH_1     = 4'd1,
    GLYPH_2     = 4'd2,
    GLYPH_3     = 4'd3,
    GLYPH_4     = 4'd4,
    GLYPH_5     = 4'd5,
    GLYPH_6     = 4'd6,
    GLYPH_7     = 4'd7,
    GLYPH_8     = 4'd8,
    GLYPH_9     = 4'd9,
    GLYPH_DASH  = 4'd10,
    GLYPH_BLANK = 4'd15
  } glyph_e;

  // Bit 6 is segment g, bit 0 is segment a, low lights the segment
  typedef logic [6:0] seg_t;

  // Index 5 is the leftmost digit
  typedef glyph_e [5:0] glyph_row_t;

  function automatic seg_t seg_encode(input glyph_e g);
    case (g)
      GLYPH_0:    return 7'b1000000;
      GLYPH_1:    return 7'b1111001;
      GLYPH_2:    return 7'b0100100;
      GLYPH_3:    return 7'b0110000;
      GLYPH_4:    return 7'b0011001;
      GLYPH_5:    return 7'b0010010;
      GLYPH_6:    return 7'b0000010;
      GLYPH_7:    return 7'b1111000;
      GLYPH_8:    return 7'b0000000;
      GLYPH_9:    return 7'b0010000;
      GLYPH_DASH: return 7'b0111111;
      default:    return 7'b1111111;
    endcase
  endfunction

endpackage

`default_nettype wire

/* hw/door_lock_top.sv */
// Keypad door lock top level: keypad scanner, PIN entry and check, lock FSM
// and display driver. All times are in clk cycles.
`timescale 1ns/1ns
`default_nettype none

module door_lock_top #(
  parameter int             DEBOUNCE_CYCLES = 1000,
  parameter lock_pkg::pin_t MASTER_PIN      = 16'h1234,
  parameter lock_pkg::pin_t USER_PIN        = 16'h2580,
  parameter bit             USER_EN         = 1'b1,
  parameter int             LOCKOUT_UNIT    = 1000,
  parameter int             RELOCK_CYCLES   = 5000,
  parameter int             BIP_CYCLES      = 5000
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [3:0]        col,
  output logic [3:0]        row,
  input  logic              door_closed,
  input  logic              inside_btn,
  output logic              lock,
  output logic              bip,
  output display_pkg::seg_t hex0,
  output display_pkg::seg_t hex1,
  output display_pkg::seg_t hex2,
  output display_pkg::seg_t hex3,
  output display_pkg::seg_t hex4,
  output display_pkg::seg_t hex5
);

  logic                    key_valid;
  lock_pkg::key_e          key_code;
  logic                    match_valid;
  logic                    match;
  display_pkg::glyph_row_t glyphs;
  logic                    glyph_load;

  pin_if i_pin_if ();

  keypad_scanner #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) i_keypad_scanner (
    .clk       (clk),
    .rst       (rst),
    .col       (col),
    .row       (row),
    .key_valid (key_valid),
    .key_code  (key_code)
  );

  pin_entry i_pin_entry (
    .clk       (clk),
    .rst       (rst),
    .key_valid (key_valid),
    .key_code  (key_code),
    .pin       (i_pin_if.entry)
  );

  pin_checker #(
    .MASTER_PIN (MASTER_PIN),
    .USER_PIN   (USER_PIN),
    .USER_EN    (USER_EN)
  ) i_pin_checker (
    .clk         (clk),
    .rst         (rst),
    .pin         (i_pin_if.ctrl),
    .match_valid (match_valid),
    .match       (match)
  );

  lock_controller #(
    .LOCKOUT_UNIT  (LOCKOUT_UNIT),
    .RELOCK_CYCLES (RELOCK_CYCLES),
    .BIP_CYCLES    (BIP_CYCLES)
  ) i_lock_controller (
    .clk         (clk),
    .rst         (rst),
    .pin         (i_pin_if.ctrl),
    .match_valid (match_valid),
    .match       (match),
    .door_closed (door_closed),
    .inside_btn  (inside_btn),
    .lock        (lock),
    .bip         (bip),
    .glyphs      (glyphs),
    .glyph_load  (glyph_load)
  );

  seg_display i_seg_display (
    .clk        (clk),
    .rst        (rst),
    .glyphs     (glyphs),
    .glyph_load (glyph_load),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3),
    .hex4       (hex4),
    .hex5       (hex5)
  );

endmodule

`default_nettype wire

/* hw/keypad_scanner.sv */
// Scans a 4x4 active-low matrix keypad one row per cycle, debounces a single
// pressed key and emits a one-cycle key event with its decoded code.
// A new event needs a full release first.
`timescale 1ns/1ns
`default_nettype none

module keypad_scanner #(
  parameter int DEBOUNCE_CYCLES = 1000
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [3:0]        col,
  output logic [3:0]        row,
  output logic              key_valid,
  output lock_pkg::key_e    key_code
);

  localparam int CNT_W = (DEBOUNCE_CYCLES > 2) ? $clog2(DEBOUNCE_CYCLES) : 1;

  typedef enum logic [1:0] {
    SC_IDLE,
    SC_DEBOUNCE,
    SC_RELEASE
  } scan_state_e;

  scan_state_e      state;
  logic [1:0]       row_idx;
  logic [3:0]       col_q;
  logic [CNT_W-1:0] cnt;
  logic             one_low;
  logic             fire;

  function automatic lock_pkg::key_e decode_key(input logic [1:0] r, input logic [3:0] c);
    logic [1:0] ci;
    case (c)
      4'b1110: ci = 2'd0;
      4'b1101: ci = 2'd1;
      4'b1011: ci = 2'd2;
      default: ci = 2'd3;
    endcase
    case ({r, ci})
      4'h0:    return lock_pkg::KEY_1;
      4'h1:    return lock_pkg::KEY_2;
      4'h2:    return lock_pkg::KEY_3;
      4'h3:    return lock_pkg::KEY_A;
      4'h4:    return lock_pkg::KEY_4;
      4'h5:    return lock_pkg::KEY_5;
      4'h6:    return lock_pkg::KEY_6;
      4'h7:    return lock_pkg::KEY_B;
      4'h8:    return lock_pkg::KEY_7;
      4'h9:    return lock_pkg::KEY_8;
      4'hA:    return lock_pkg::KEY_9;
      4'hB:    return lock_pkg::KEY_C;
      4'hC:    return lock_pkg::KEY_STAR;
      4'hD:    return lock_pkg::KEY_0;
      4'hE:    return lock_pkg::KEY_HASH;
      default: return lock_pkg::KEY_D;
    endcase
  endfunction

  assign row     = ~(4'b0001 << row_idx);
  assign one_low = col inside {4'b1110, 4'b1101, 4'b1011, 4'b0111};
  assign fire    = (state == SC_DEBOUNCE) && (col == col_q) &&
                   (cnt == CNT_W'(DEBOUNCE_CYCLES - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= SC_IDLE;
      row_idx   <= 2'd0;
      col_q     <= 4'hF;
      cnt       <= '0;
      key_valid <= 1'b0;
    end else begin
      key_valid <= fire;
      case (state)
        SC_IDLE: begin
          if (one_low) begin
            col_q <= col;
            cnt   <= CNT_W'(1);
            state <= SC_DEBOUNCE;
          end else begin
            row_idx <= row_idx + 2'd1;
          end
        end
        SC_DEBOUNCE: begin
          if (fire) begin
            state <= SC_RELEASE;
          end else if (col == col_q) begin
            cnt <= cnt + CNT_W'(1);
          end else begin
            // Bounce, release or a second key on this row
            state <= SC_IDLE;
          end
        end
        default: begin
          if (col == 4'hF) begin
            state <= SC_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      key_code <= decode_key(row_idx, col_q);
    end
  end

  a_single_event: assert property (@(posedge clk) disable iff (rst)
    key_valid |=> !key_valid);

endmodule

`default_nettype wire

/* hw/lock_controller.sv */
// Lock FSM with growing lockout, auto relock, inside button and open-door buzzer.
// Also builds the glyph row for the display and loads it whenever it changes.
`timescale 1ns/1ns
`default_nettype none

module lock_controller #(
  parameter int LOCKOUT_UNIT  = 1000,
  parameter int RELOCK_CYCLES = 5000,
  parameter int BIP_CYCLES    = 5000
) (
  input  logic                    clk,
  input  logic                    rst,
  pin_if.ctrl                     pin,
  input  logic                    match_valid,
  input  logic                    match,
  input  logic                    door_closed,
  input  logic                    inside_btn,
  output logic                    lock,
  output logic                    bip,
  output display_pkg::glyph_row_t glyphs,
  output logic                    glyph_load
);

  localparam int LOCKOUT_MAX = LOCKOUT_UNIT * lock_pkg::LOCKOUT_MULT[3];
  localparam int TMR_MAX_A   = (LOCKOUT_MAX > RELOCK_CYCLES) ? LOCKOUT_MAX : RELOCK_CYCLES;
  localparam int TMR_MAX     = (TMR_MAX_A > BIP_CYCLES) ? TMR_MAX_A : BIP_CYCLES;
  localparam int TMR_W       = $clog2(TMR_MAX + 1);

  lock_pkg::lock_state_e   state;
  lock_pkg::fail_cnt_t     fails;
  logic [TMR_W-1:0]        timer;
  logic [TMR_W-1:0]        lockout_len;
  logic [1:0]              mult_idx;
  display_pkg::glyph_row_t shown;
  logic                    shown_valid;

  // Failures 1 and 2 share the first multiplier
  assign mult_idx    = (fails <= 3'd2) ? 2'd0 : 2'(fails - 3'd2);
  assign lockout_len = TMR_W'(LOCKOUT_UNIT * lock_pkg::LOCKOUT_MULT[mult_idx]);
  assign pin.flush   = (state != lock_pkg::S_LOCKED);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= lock_pkg::S_LOCKED;
      fails <= '0;
      timer <= '0;
      lock  <= 1'b1;
      bip   <= 1'b0;
    end else begin
      case (state)
        lock_pkg::S_LOCKED: begin
          if (pin.submit) begin
            state <= lock_pkg::S_CHECK;
          end else if (inside_btn) begin
            lock  <= 1'b0;
            timer <= '0;
            state <= lock_pkg::S_CLOSED;
          end
        end
        lock_pkg::S_CHECK: begin
          if (match_valid) begin
            timer <= '0;
            if (match) begin
              fails <= '0;
              lock  <= 1'b0;
              state <= lock_pkg::S_CLOSED;
            end else begin
              if (fails != lock_pkg::fail_cnt_t'(lock_pkg::MAX_FAILS)) begin
                fails <= fails + 3'd1;
              end
              state <= lock_pkg::S_LOCKOUT;
            end
          end
        end
        lock_pkg::S_LOCKOUT: begin
          if (timer == lockout_len - 1'b1) begin
            timer <= '0;
            state <= lock_pkg::S_LOCKED;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        lock_pkg::S_CLOSED: begin
          if (!door_closed) begin
            timer <= '0;
            state <= lock_pkg::S_OPEN;
          end else if (inside_btn || timer == TMR_W'(RELOCK_CYCLES - 1)) begin
            lock  <= 1'b1;
            state <= lock_pkg::S_LOCKED;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        default: begin
          if (door_closed) begin
            bip   <= 1'b0;
            timer <= '0;
            state <= lock_pkg::S_CLOSED;
          end else if (timer == TMR_W'(BIP_CYCLES - 1)) begin
            bip <= 1'b1;
          end else begin
            timer <= timer + 1'b1;
          end
        end
      endcase
    end
  end

  always_comb begin
    for (int i = 0; i < 6; i++) begin
      glyphs[i] = display_pkg::GLYPH_BLANK;
    end
    case (state)
      lock_pkg::S_LOCKED: begin
        glyphs[5] = display_pkg::GLYPH_DASH;
        glyphs[4] = display_pkg::GLYPH_DASH;
        // Entered digits sit right-aligned, newest on the right
        for (int i = 0; i < lock_pkg::PIN_LEN; i++) begin
          if (lock_pkg::fill_t'(i) < pin.filled) begin
            glyphs[i] = display_pkg::glyph_e'(pin.digits[i]);
          end
        end
      end
      lock_pkg::S_CHECK: begin
        glyphs[5] = display_pkg::GLYPH_DASH;
        glyphs[4] = display_pkg::GLYPH_DASH;
      end
      lock_pkg::S_LOCKOUT: begin
        for (int i = 0; i < 6; i++) begin
          glyphs[i] = display_pkg::GLYPH_DASH;
        end
      end
      default: ;
    endcase
  end

  assign glyph_load = !shown_valid || (glyphs != shown);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      shown_valid <= 1'b0;
    end else if (glyph_load) begin
      shown_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (glyph_load) begin
      shown <= glyphs;
    end
  end

  a_bip_open: assert property (@(posedge clk) disable iff (rst)
    bip |-> state == lock_pkg::S_OPEN);

endmodule

`default_nettype wire

/* hw/lock_pkg.sv */
// Shared types and constants for the keypad, PIN path and lock controller.
// Modules refer to these by scoped name, for example lock_pkg::pin_t.
`default_nettype none

package lock_pkg;

  localparam int PIN_LEN = 4;

  typedef logic [3:0] digit_t;

  // Index 3 holds the first digit entered, index 0 the last
  typedef digit_t [PIN_LEN-1:0] pin_t;

  // Count of digits entered, 0 to PIN_LEN
  typedef logic [$clog2(PIN_LEN + 1)-1:0] fill_t;

  typedef enum logic [3:0] {
    KEY_0    = 4'd0,
    KEY_1    = 4'd1,
    KEY_2    = 4'd2,
    KEY_3    = 4'd3,
    KEY_4    = 4'd4,
    KEY_5    = 4'd5,
    KEY_6    = 4'd6,
    KEY_7    = 4'd7,
    KEY_8    = 4'd8,
    KEY_9    = 4'd9,
    KEY_A    = 4'd10,
    KEY_B    = 4'd11,
    KEY_C    = 4'd12,
    KEY_D    = 4'd13,
    KEY_STAR = 4'd14,
    KEY_HASH = 4'd15
  } key_e;

  typedef enum logic [2:0] {
    S_LOCKED,
    S_CHECK,
    S_LOCKOUT,
    S_CLOSED,
    S_OPEN
  } lock_state_e;

  localparam int MAX_FAILS = 5;
  typedef logic [2:0] fail_cnt_t;

  // Lockout length in units, for 1-2, 3, 4 and 5+ failures
  localparam int LOCKOUT_MULT [4] = '{1, 10, 20, 30};

endpackage

`default_nettype wire

/* hw/pin_checker.sv */
// Compares a submitted PIN with the master PIN and, when enabled, the user PIN.
// The result is valid for one cycle, the cycle after submit.
`timescale 1ns/1ns
`default_nettype none

module pin_checker #(
  parameter lock_pkg::pin_t MASTER_PIN = 16'h1234,
  parameter lock_pkg::pin_t USER_PIN   = 16'h2580,
  parameter bit             USER_EN    = 1'b1
) (
  input  logic clk,
  input  logic rst,
  pin_if.ctrl  pin,
  output logic match_valid,
  output logic match
);

  logic hit;

  assign hit = (pin.digits == MASTER_PIN) || (USER_EN && (pin.digits == USER_PIN));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      match_valid <= 1'b0;
    end else begin
      match_valid <= pin.submit;
    end
  end

  always_ff @(posedge clk) begin
    if (pin.submit) begin
      match <= hit;
    end
  end

endmodule

`default_nettype wire

/* hw/pin_entry.sv */
// Collects digit keys into a four-digit PIN; '*' clears, '#' submits a full PIN.
// While flush is high the entry stays empty and keys are dropped.
`timescale 1ns/1ns
`default_nettype none

module pin_entry (
  input  logic           clk,
  input  logic           rst,
  input  logic           key_valid,
  input  lock_pkg::key_e key_code,
  pin_if.entry           pin
);

  localparam lock_pkg::fill_t FULL = lock_pkg::fill_t'(lock_pkg::PIN_LEN);

  logic full;

  assign full = (pin.filled == FULL);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pin.digits <= '0;
      pin.filled <= '0;
      pin.submit <= 1'b0;
    end else begin
      pin.submit <= 1'b0;
      // Digits stay valid through the submit cycle and clear at its end
      if (pin.flush || pin.submit) begin
        pin.digits <= '0;
        pin.filled <= '0;
      end else if (key_valid) begin
        if (key_code <= lock_pkg::KEY_9) begin
          pin.digits <= {pin.digits[lock_pkg::PIN_LEN-2:0], lock_pkg::digit_t'(key_code)};
          if (!full) begin
            pin.filled <= pin.filled + 1'b1;
          end
        end else if (key_code == lock_pkg::KEY_STAR) begin
          pin.digits <= '0;
          pin.filled <= '0;
        end else if (key_code == lock_pkg::KEY_HASH && full) begin
          pin.submit <= 1'b1;
        end
      end
    end
  end

  a_submit_full: assert property (@(posedge clk) disable iff (rst)
    pin.submit |-> $past(pin.filled) == FULL);

endmodule

`default_nettype wire

/* hw/pin_if.sv */
// PIN entry bus between pin_entry and the control side.
// The entry side drives the digits, the fill count and submit; control drives flush.
`timescale 1ns/1ns
`default_nettype none

interface pin_if;

  lock_pkg::pin_t  digits;
  lock_pkg::fill_t filled;
  logic            submit;
  logic            flush;

  modport entry (output digits, output filled, output submit, input flush);
  modport ctrl (input digits, input filled, input submit, output flush);

endinterface

`default_nettype wire

/* hw/seg_display.sv */
// Six-digit seven-segment driver. Glyphs are captured on glyph_load and each
// is encoded to active-low segments; blanks are shown after reset.
`timescale 1ns/1ns
`default_nettype none

module seg_display (
  input  logic                    clk,
  input  logic                    rst,
  input  display_pkg::glyph_row_t glyphs,
  input  logic                    glyph_load,
  output display_pkg::seg_t       hex0,
  output display_pkg::seg_t       hex1,
  output display_pkg::seg_t       hex2,
  output display_pkg::seg_t       hex3,
  output display_pkg::seg_t       hex4,
  output display_pkg::seg_t       hex5
);

  display_pkg::glyph_row_t row_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 6; i++) begin
        row_q[i] <= display_pkg::GLYPH_BLANK;
      end
    end else if (glyph_load) begin
      row_q <= glyphs;
    end
  end

  assign hex0 = display_pkg::seg_encode(row_q[0]);
  assign hex1 = display_pkg::seg_encode(row_q[1]);
  assign hex2 = display_pkg::seg_encode(row_q[2]);
  assign hex3 = display_pkg::seg_encode(row_q[3]);
  assign hex4 = display_pkg::seg_encode(row_q[4]);
  assign hex5 = display_pkg::seg_encode(row_q[5]);

endmodule

`default_nettype wire

/* test/door_lock_tb.sv */
// Directed testbench for the keypad door lock. A keypad model answers the row
// scan, each test drives keys, door and button on the falling edge and checks
// lock, bip and the six display digits. Run through the Makefile sim target.
`timescale 1ns/1ns
`default_nettype none

module door_lock_tb;

  localparam int             DEBOUNCE     = 3;
  localparam lock_pkg::pin_t MASTER       = 16'h1234;
  localparam lock_pkg::pin_t USER         = 16'h2580;
  localparam int             LOCKOUT_UNIT = 20;
  localparam int             RELOCK       = 30;
  localparam int             BIP          = 25;
  // Longest test is well under 1000 cycles, so this leaves a wide margin
  localparam int             CYCLE_LIMIT  = 20000;

  logic              clk;
  logic              rst;
  logic [3:0]        col;
  logic [3:0]        row;
  logic              door_closed;
  logic              inside_btn;
  logic              lock;
  logic              bip;
  display_pkg::seg_t hex0, hex1, hex2, hex3, hex4, hex5;

  lock_pkg::key_e held_key;
  logic           key_down;
  logic [1:0]     key_row;
  logic [1:0]     key_col;
  int             cycle;
  int             checks;
  int             errors;

  door_lock_top #(
    .DEBOUNCE_CYCLES (DEBOUNCE),
    .MASTER_PIN      (MASTER),
    .USER_PIN        (USER),
    .USER_EN         (1'b1),
    .LOCKOUT_UNIT    (LOCKOUT_UNIT),
    .RELOCK_CYCLES   (RELOCK),
    .BIP_CYCLES      (BIP)
  ) i_door_lock_top (
    .clk (clk), .rst (rst), .col (col), .row (row),
    .door_closed (door_closed), .inside_btn (inside_btn), .lock (lock), .bip (bip),
    .hex0 (hex0), .hex1 (hex1), .hex2 (hex2), .hex3 (hex3), .hex4 (hex4), .hex5 (hex5)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Run stopped: tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Keypad layout, returned as {row, column}
  function automatic logic [3:0] key_position(input lock_pkg::key_e k);
    case (k)
      lock_pkg::KEY_1:    return 4'h0;
      lock_pkg::KEY_2:    return 4'h1;
      lock_pkg::KEY_3:    return 4'h2;
      lock_pkg::KEY_A:    return 4'h3;
      lock_pkg::KEY_4:    return 4'h4;
      lock_pkg::KEY_5:    return 4'h5;
      lock_pkg::KEY_6:    return 4'h6;
      lock_pkg::KEY_B:    return 4'h7;
      lock_pkg::KEY_7:    return 4'h8;
      lock_pkg::KEY_8:    return 4'h9;
      lock_pkg::KEY_9:    return 4'hA;
      lock_pkg::KEY_C:    return 4'hB;
      lock_pkg::KEY_STAR: return 4'hC;
      lock_pkg::KEY_0:    return 4'hD;
      lock_pkg::KEY_HASH: return 4'hE;
      default:            return 4'hF;
    endcase
  endfunction

  // A pressed key pulls its column low while its row is driven low
  always_comb begin
    {key_row, key_col} = key_position(held_key);
    col = 4'hF;
    if (key_down && !row[key_row]) begin
      col[key_col] = 1'b0;
    end
  end

  // Lit segments as abcdefg bits in g..a order, inverted for the active-low pins
  function automatic display_pkg::seg_t expected_segments(input display_pkg::glyph_e g);
    logic [6:0] lit;
    case (g)
      display_pkg::GLYPH_0:    lit = 7'h3F;
      display_pkg::GLYPH_1:    lit = 7'h06;
      display_pkg::GLYPH_2:    lit = 7'h5B;
      display_pkg::GLYPH_3:    lit = 7'h4F;
      display_pkg::GLYPH_4:    lit = 7'h66;
      display_pkg::GLYPH_5:    lit = 7'h6D;
      display_pkg::GLYPH_6:    lit = 7'h7D;
      display_pkg::GLYPH_7:    lit = 7'h07;
      display_pkg::GLYPH_8:    lit = 7'h7F;
      display_pkg::GLYPH_9:    lit = 7'h6F;
      display_pkg::GLYPH_DASH: lit = 7'h40;
      default:                 lit = 7'h00;
    endcase
    return ~lit;
  endfunction

  task automatic check_seg(input display_pkg::seg_t actual, input display_pkg::glyph_e g,
                           input string what);
    checks++;
    if (actual !== expected_segments(g)) begin
      errors++;
      $display("FAILED at %0t ns: %s shows %b, expected %s (%b)", $time, what, actual,
               g.name(), expected_segments(g));
    end
  endtask

  task automatic check_bit(input logic actual, input logic expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic check_cycles(input int actual, input int low, input int high,
                              input string what);
    checks++;
    if (actual < low || actual > high) begin
      errors++;
      $display("FAILED at %0t ns: %s took %0d cycles, expected %0d to %0d", $time, what,
               actual, low, high);
    end
  endtask

  task automatic check_display(input display_pkg::glyph_e g5, input display_pkg::glyph_e g4,
                               input display_pkg::glyph_e g3, input display_pkg::glyph_e g2,
                               input display_pkg::glyph_e g1, input display_pkg::glyph_e g0);
    check_seg(hex5, g5, "hex5");
    check_seg(hex4, g4, "hex4");
    check_seg(hex3, g3, "hex3");
    check_seg(hex2, g2, "hex2");
    check_seg(hex1, g1, "hex1");
    check_seg(hex0, g0, "hex0");
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  function automatic logic output_level(input bit want_bip);
    return want_bip ? bip : lock;
  endfunction

  task automatic wait_for_level(input bit want_bip, input logic value, input int limit);
    int n;
    n = 0;
    while (output_level(want_bip) !== value && n < limit) begin
      @(negedge clk);
      n++;
    end
    checks++;
    if (output_level(want_bip) !== value) begin
      errors++;
      $display("%s did not go to %b within %0d cycles", want_bip ? "bip" : "lock", value,
               limit);
    end
  endtask

  task automatic wait_for_hex0(input display_pkg::glyph_e g, input int limit);
    int n;
    n = 0;
    while (hex0 !== expected_segments(g) && n < limit) begin
      @(negedge clk);
      n++;
    end
    checks++;
    if (hex0 !== expected_segments(g)) begin
      errors++;
      $display("Display digit 0 did not show %s within %0d cycles", g.name(), limit);
    end
  endtask

  task automatic hold_key(input lock_pkg::key_e k, input int n);
    @(negedge clk);
    held_key = k;
    key_down = 1'b1;
    wait_cycles(n);
  endtask

  task automatic release_keys(input int n);
    @(negedge clk);
    key_down = 1'b0;
    wait_cycles(n);
  endtask

  task automatic press_key(input lock_pkg::key_e k);
    hold_key(k, 12);
    release_keys(12);
  endtask

  task automatic enter_pin(input lock_pkg::pin_t p);
    for (int i = lock_pkg::PIN_LEN - 1; i >= 0; i--) begin
      press_key(lock_pkg::key_e'(p[i]));
    end
  endtask

  task automatic submit_pin(input lock_pkg::pin_t p);
    enter_pin(p);
    press_key(lock_pkg::KEY_HASH);
  endtask

  task automatic pulse_inside_button();
    @(negedge clk);
    inside_btn = 1'b1;
    @(negedge clk);
    inside_btn = 1'b0;
    wait_cycles(2);
  endtask

  function automatic lock_pkg::pin_t random_wrong_pin();
    lock_pkg::pin_t p;
    do begin
      for (int i = 0; i < lock_pkg::PIN_LEN; i++) begin
        p[i] = lock_pkg::digit_t'($urandom % 10);
      end
    end while (p == MASTER || p == USER);
    return p;
  endfunction

  task automatic finish_test(input string name, input int errors_before);
    $display("%s: %s", name, (errors == errors_before) ? "ok" : "errors found");
  endtask

  task automatic test_entry_display();
    int e0;
    e0 = errors;
    check_bit(lock, 1'b1, "lock after reset");
    check_bit(bip, 1'b0, "bip after reset");
    check_display(display_pkg::GLYPH_BLANK, display_pkg::GLYPH_BLANK, display_pkg::GLYPH_BLANK,
                  display_pkg::GLYPH_BLANK, display_pkg::GLYPH_BLANK, display_pkg::GLYPH_BLANK);
    wait_cycles(2);
    check_display(display_pkg::GLYPH_DASH, display_pkg::GLYPH_DASH, display_pkg::GLYPH_BLANK,
                  display_pkg::GLYPH_BLANK, display_pkg::GLYPH_BLANK, display_pkg::GLYPH_BLANK);
    press_key(lock_pkg::KEY_5);
    press_key(lock_pkg::KEY_7);
    press_key(lock_pkg::KEY_2);
    check_display(display_pkg::GLYPH_DASH, display_pkg::GLYPH_DASH, display_pkg::GLYPH_BLANK,
                  display_pkg::GLYPH_5, display_pkg::GLYPH_7, display_pkg::GLYPH_2);
    press_key(lock_pkg::KEY_STAR);
    finish_test("test 1 reset and entry display", e0);
  endtask

  task automatic test_master_relock();
    int e0;
    e0 = errors;
    submit_pin(MASTER);
    check_bit(lock, 1'b0, "lock after master PIN");
    check_display(display_pkg::GLYPH_BLANK, display_pkg::GLYPH_BLANK, display_pkg::GLYPH_BLANK,
                  display_pkg::GLYPH_BLANK, display_pkg::GLYPH_BLANK, display_pkg::GLYPH_BLANK);
    @(negedge clk);
    door_closed = 1'b0;
    wait_cycles(5);
    door_closed = 1'b1;
    wait_cycles(RELOCK - 3);
    check_bit(lock, 1'b0, "lock before relock time");
    wait_for_level(1'b0, 1'b1, 10);
    finish_test("test 2 master PIN and auto relock", e0);
  endtask

  task automatic test_user_pin_and_clear();
    int e0;
    e0 = errors;
    submit_pin(USER);
    check_bit(lock, 1'b0, "lock after user PIN");
    pulse_inside_button();
    check_bit(lock, 1'b1, "lock after inside button");
    press_key(lock_pkg::KEY_4);
    press_key(lock_pkg::KEY_9);
    press_key(lock_pkg::KEY_STAR);
    check_display(display_pkg::GLYPH_DASH, display_pkg::GLYPH_DASH, display_pkg::GLYPH_BLANK,
                  display_pkg::GLYPH_BLANK, display_pkg::GLYPH_BLANK, display_pkg::GLYPH_BLANK);
    press_key(lock_pkg::KEY_3);
    press_key(lock_pkg::KEY_1);
    press_key(lock_pkg::KEY_6);
    press_key(lock_pkg::KEY_HASH);
    check_bit(lock, 1'b1, "lock after short PIN");
    check_display(display_pkg::GLYPH_DASH, display_pkg::GLYPH_DASH, display_pkg::GLYPH_BLANK,
                  display_pkg::GLYPH_3, display_pkg::GLYPH_1, display_pkg::GLYPH_6);
    press_key(lock_pkg::KEY_STAR);
    finish_test("test 3 user PIN, clear and short PIN", e0);
  endtask

  task automatic test_wrong_pin_lockout();
    int e0;
    e0 = errors;
    enter_pin(random_wrong_pin());
    hold_key(lock_pkg::KEY_HASH, 12);
    check_display(display_pkg::GLYPH_DASH, display_pkg::GLYPH_DASH, display_pkg::GLYPH_DASH,
                  display_pkg::GLYPH_DASH, display_pkg::GLYPH_DASH, display_pkg::GLYPH_DASH);
    check_bit(lock, 1'b1, "lock during lockout");
    // The short first lockout needs a quick key while it runs
    release_keys(2);
    hold_key(lock_pkg::KEY_8, 8);
    check_seg(hex0, display_pkg::GLYPH_DASH, "hex0 during lockout");
    release_keys(12);
    wait_for_hex0(display_pkg::GLYPH_BLANK, 2 * LOCKOUT_UNIT);
    check_display(display_pkg::GLYPH_DASH, display_pkg::GLYPH_DASH, display_pkg::GLYPH_BLANK,
                  display_pkg::GLYPH_BLANK, display_pkg::GLYPH_BLANK, display_pkg::GLYPH_BLANK);
    submit_pin(MASTER);
    check_bit(lock, 1'b0, "lock after lockout and master PIN");
    pulse_inside_button();
    finish_test("test 4 wrong PIN lockout", e0);
  endtask

  task automatic test_buzzer_and_button();
    int e0;
    e0 = errors;
    submit_pin(MASTER);
    check_bit(lock, 1'b0, "lock before door opens");
    @(negedge clk);
    door_closed = 1'b0;
    wait_cycles(BIP - 5);
    check_bit(bip, 1'b0, "bip before open time");
    wait_for_level(1'b1, 1'b1, 10);
    door_closed = 1'b1;
    wait_cycles(2);
    check_bit(bip, 1'b0, "bip after door closes");
    check_bit(lock, 1'b0, "lock after door closes");
    pulse_inside_button();
    check_bit(lock, 1'b1, "lock after inside button");
    finish_test("test 5 open-door buzzer and inside button", e0);
  endtask

  task automatic test_growing_lockout();
    int e0;
    int start;
    e0 = errors;
    for (int n = 0; n < 2; n++) begin
      submit_pin(random_wrong_pin());
      wait_for_hex0(display_pkg::GLYPH_BLANK, 2 * LOCKOUT_UNIT);
    end
    enter_pin(random_wrong_pin());
    start = cycle;
    hold_key(lock_pkg::KEY_HASH, 12);
    check_seg(hex0, display_pkg::GLYPH_DASH, "hex0 in third lockout");
    release_keys(12);
    // Correct PIN well inside the 10-unit lockout is dropped
    submit_pin(MASTER);
    check_bit(lock, 1'b1, "lock after PIN during lockout");
    check_seg(hex0, display_pkg::GLYPH_DASH, "hex0 after PIN during lockout");
    wait_for_hex0(display_pkg::GLYPH_BLANK, 10 * LOCKOUT_UNIT);
    check_cycles(cycle - start, 10 * LOCKOUT_UNIT, 10 * LOCKOUT_UNIT + 12, "third lockout");
    submit_pin(MASTER);
    check_bit(lock, 1'b0, "lock after third lockout");
    pulse_inside_button();
    finish_test("test 6 growing lockout", e0);
  endtask

  initial begin
    void'($urandom(32'h9119_c4fe));
    cycle       = 0;
    checks      = 0;
    errors      = 0;
    rst         = 1'b1;
    door_closed = 1'b1;
    inside_btn  = 1'b0;
    key_down    = 1'b0;
    held_key    = lock_pkg::KEY_0;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    test_entry_display();
    test_master_relock();
    test_user_pin_and_clear();
    test_wrong_pin_lockout();
    test_buzzer_and_button();
    test_growing_lockout();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
